//--- filelist.f
common/dbg_pkg.sv
common/snap_pkg.sv
debug/cmd_decoder.sv
debug/run_ctrl.sv
debug/snap_serializer.sv
verilog/dbg_top.sv
sim/dbg_top_asserts.sv
sim/tb_dbg_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_dbg_top
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_dbg_top.sv
`timescale 1ns/100ps

module tb_dbg_top;

	localparam int SNAP_WORDS = snap_pkg::SNAP_WORDS_DEF;
	localparam int INIT_CYCLES = 4;
	localparam int DUMP_BYTES = SNAP_WORDS * snap_pkg::BYTES_PER_WORD;
	localparam int RESET_CYCLES = 5;
	localparam int TIMEOUT = 5000;
	localparam int QUIET = 20;
	localparam int NUM_TESTS = 5;

	// Columns: command bytes (first byte lowest), byte count, run length,
	// enable cycles, bytes written, random back-pressure
	localparam int STIM [NUM_TESTS][6] = '{
		'{32'h63, 1, 5, 5, DUMP_BYTES, 0},
		'{32'h70, 1, 3, 1, DUMP_BYTES, 0},
		'{32'h41, 1, 3, 0, 0, 0},
		'{32'h63, 1, 9, 9, DUMP_BYTES, 1},
		'{32'h6370, 2, 4, 5, 2 * DUMP_BYTES, 1}
	};
	string test_name [NUM_TESTS] = '{"run", "step", "unknown byte", "back-pressure",
		"step then run"};

	logic clk;
	logic rst_i;
	logic [7:0] rx_data_i;
	logic rx_empty_i;
	logic rd_o;
	logic [7:0] tx_data_o;
	logic tx_full_i;
	logic wr_o;
	logic target_init_o;
	logic target_en_o;
	logic target_done_i;
	logic [SNAP_WORDS*snap_pkg::WORD_W-1:0] snapshot_i;

	logic [7:0] rx_q [$];
	logic [7:0] exp_q [$];
	int burst_q [$];
	logic [31:0] snap_words [SNAP_WORDS];
	logic [31:0] rng;
	int run_len;
	bit bp_mode;
	int run_cnt;
	bit en_no_done;
	int pop_cnt;
	int en_cnt;
	int wr_cnt;
	int err_cnt;

	dbg_top dut0
	(
		.clk(clk),
		.rst_i(rst_i),
		.rx_data_i(rx_data_i),
		.rx_empty_i(rx_empty_i),
		.rd_o(rd_o),
		.tx_data_o(tx_data_o),
		.tx_full_i(tx_full_i),
		.wr_o(wr_o),
		.target_init_o(target_init_o),
		.target_en_o(target_en_o),
		.target_done_i(target_done_i),
		.snapshot_i(snapshot_i)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic refill_snapshot();
		for (int w = 0; w < SNAP_WORDS; w++)
		begin
			rng = xorshift32(rng);
			snap_words[w] = rng;
			snapshot_i[w*snap_pkg::WORD_W +: snap_pkg::WORD_W] <= rng;
		end
	endtask

	// Word 0 first, each word low byte first
	task automatic queue_expected_dump();
		for (int w = 0; w < SNAP_WORDS; w++)
		begin
			for (int b = 0; b < snap_pkg::BYTES_PER_WORD; b++)
			begin
				exp_q.push_back(snap_words[w][8*b +: 8]);
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// FIFO and target models
	//////////////////////////////

	always @(posedge clk)
	begin
		logic [7:0] exp_byte;
		bit capture;
		int burst;
		if (!rst_i)
		begin
			if (rd_o)
			begin
				rx_q.delete(0);
				pop_cnt++;
			end
			if (target_en_o)
			begin
				en_cnt++;
			end
			// Run ends on done, a step one cycle after its enable
			capture = (target_en_o && target_done_i) || (en_no_done && !target_en_o);
			burst = target_en_o ? run_cnt + 1 : run_cnt;
			en_no_done = target_en_o && !target_done_i;
			run_cnt = target_en_o ? run_cnt + 1 : 0;
			target_done_i <= (run_cnt > 0) && (run_cnt == run_len - 1);
			if (capture)
			begin
				burst_q.push_back(burst);
				queue_expected_dump();
				refill_snapshot();
			end
			if (wr_o)
			begin
				wr_cnt++;
				assert (!tx_full_i)
				else
				begin
					$display("Write to the full transmit FIFO at %0t", $time);
					err_cnt++;
				end
				if (exp_q.size() == 0)
				begin
					$display("Unexpected write of 0x%02h at %0t", tx_data_o, $time);
					err_cnt++;
				end
				else
				begin
					exp_byte = exp_q.pop_front();
					assert (tx_data_o == exp_byte)
					else
					begin
						$display("** Error at %0t: tx_data_o = 0x%02h, expected 0x%02h",
							$time, tx_data_o, exp_byte);
						err_cnt++;
					end
				end
			end
			rng = xorshift32(rng);
			tx_full_i <= bp_mode && (rng[1:0] == 2'b00);
		end
		rx_empty_i <= (rx_q.size() == 0);
		rx_data_i <= (rx_q.size() == 0) ? 8'h00 : rx_q[0];
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int init_len;
		int waited;
		int err_base;
		int pop_base;
		int en_base;
		int wr_base;
		int failed;
		logic [7:0] cmd_byte;
		int exp_burst;
		int got_burst;
		rst_i = 1'b1;
		rx_data_i = 8'h00;
		rx_empty_i = 1'b1;
		tx_full_i = 1'b0;
		target_done_i = 1'b0;
		rng = 32'd49;
		run_len = 3;
		bp_mode = 1'b0;
		run_cnt = 0;
		en_no_done = 1'b0;
		pop_cnt = 0;
		en_cnt = 0;
		wr_cnt = 0;
		err_cnt = 0;
		failed = 0;
		refill_snapshot();

		repeat (RESET_CYCLES - 1)
		begin
			@(negedge clk);
			assert (!(rd_o || wr_o || target_en_o || target_init_o))
			else
			begin
				$display("Outputs active during reset at %0t", $time);
				err_cnt++;
			end
		end
		@(posedge clk);
		rst_i <= 1'b0;

		// Init pulse, nothing popped or written meanwhile
		init_len = 0;
		waited = 0;
		while (waited < TIMEOUT && !(init_len > 0 && !target_init_o))
		begin
			@(negedge clk);
			waited++;
			if (target_init_o)
			begin
				init_len++;
				assert (!rd_o && !wr_o)
				else
				begin
					$display("FIFO access during target init at %0t", $time);
					err_cnt++;
				end
			end
		end
		if (waited >= TIMEOUT)
		begin
			$display("Timed out waiting for the target init pulse");
			err_cnt++;
		end
		assert (init_len == INIT_CYCLES)
		else
		begin
			$display("** Error at %0t: target_init_o high for %0d cycles, expected %0d",
				$time, init_len, INIT_CYCLES);
			err_cnt++;
		end
		failed += (err_cnt != 0);
		$display("Test init: %s", (err_cnt == 0) ? "ok" : "FAILED");

		for (int t = 0; t < NUM_TESTS; t++)
		begin
			@(negedge clk);
			err_base = err_cnt;
			pop_base = pop_cnt;
			en_base = en_cnt;
			wr_base = wr_cnt;
			run_len = STIM[t][2];
			bp_mode = (STIM[t][5] != 0);
			for (int i = 0; i < STIM[t][1]; i++)
			begin
				rx_q.push_back(8'(STIM[t][0] >> (8 * i)));
			end
			waited = 0;
			while (waited < TIMEOUT && !(pop_cnt - pop_base == STIM[t][1] &&
				en_cnt - en_base == STIM[t][3] && wr_cnt - wr_base == STIM[t][4]))
			begin
				@(negedge clk);
				waited++;
			end
			if (waited >= TIMEOUT)
			begin
				$display("Test %0d timed out waiting for the commands and the dump", t);
				err_cnt++;
			end
			repeat (QUIET) @(negedge clk);
			assert (en_cnt - en_base == STIM[t][3])
			else
			begin
				$display("** Error at %0t: target_en_o cycles = %0d, expected %0d",
					$time, en_cnt - en_base, STIM[t][3]);
				err_cnt++;
			end
			assert (wr_cnt - wr_base == STIM[t][4])
			else
			begin
				$display("** Error at %0t: wr_o count = %0d, expected %0d",
					$time, wr_cnt - wr_base, STIM[t][4]);
				err_cnt++;
			end
			assert (pop_cnt - pop_base == STIM[t][1])
			else
			begin
				$display("** Error at %0t: rd_o count = %0d, expected %0d",
					$time, pop_cnt - pop_base, STIM[t][1]);
				err_cnt++;
			end
			// One enable burst per known command, in queue order
			for (int i = 0; i < STIM[t][1]; i++)
			begin
				cmd_byte = 8'(STIM[t][0] >> (8 * i));
				if (cmd_byte == 8'h63 || cmd_byte == 8'h70)
				begin
					exp_burst = (cmd_byte == 8'h63) ? STIM[t][2] : 1;
					got_burst = 0;
					if (burst_q.size() != 0)
					begin
						got_burst = burst_q.pop_front();
					end
					assert (got_burst == exp_burst)
					else
					begin
						$display("** Error at %0t: target_en_o burst %0d = %0d, expected %0d",
							$time, i, got_burst, exp_burst);
						err_cnt++;
					end
				end
			end
			burst_q.delete();
			assert (exp_q.size() == 0)
			else
			begin
				$display("Dump incomplete, %0d expected bytes never written", exp_q.size());
				err_cnt++;
				exp_q.delete();
			end
			failed += (err_cnt != err_base);
			$display("Test %0d (%s): %s", t, test_name[t], (err_cnt == err_base) ? "ok" : "FAILED");
		end

		$display("Tests run: %0d, failed: %0d, errors: %0d", NUM_TESTS + 1, failed, err_cnt);
		if (err_cnt == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- sim/dbg_top_asserts.sv
`timescale 1ns/100ps

module dbg_top_asserts
(
	input logic clk,
	input logic rst_i,
	input logic rd_i,
	input logic rx_empty_i,
	input logic wr_i,
	input logic tx_full_i,
	input logic target_init_i,
	input logic target_en_i,
	input logic dump_busy_i
);

	//////////////////////////////
	// FIFO handshakes
	//////////////////////////////

	tx_write_not_full: assert property (@(posedge clk) disable iff (rst_i)
		!(wr_i && tx_full_i))
		else $error("wr_o high while tx_full_i is high");

	rx_read_not_empty: assert property (@(posedge clk) disable iff (rst_i)
		!(rd_i && rx_empty_i))
		else $error("rd_o high while rx_empty_i is high");

	//////////////////////////////
	// Target control
	//////////////////////////////

	init_en_exclusive: assert property (@(posedge clk) disable iff (rst_i)
		!(target_en_i && target_init_i))
		else $error("target_en_o and target_init_o high together");

	// Target stays frozen while the snapshot goes out
	en_low_in_dump: assert property (@(posedge clk) disable iff (rst_i)
		dump_busy_i |-> !target_en_i)
		else $error("target_en_o high during a dump");

endmodule

bind dbg_top dbg_top_asserts u_dbg_top_asserts
(
	.clk(clk),
	.rst_i(rst_i),
	.rd_i(rd_o),
	.rx_empty_i(rx_empty_i),
	.wr_i(wr_o),
	.tx_full_i(tx_full_i),
	.target_init_i(target_init_o),
	.target_en_i(target_en_o),
	.dump_busy_i(u_snap_serializer.busy_q)
);

//--- verilog/dbg_top.sv
`timescale 1ns/100ps

module dbg_top
#(
	parameter int SNAP_WORDS = snap_pkg::SNAP_WORDS_DEF,
	parameter int INIT_CYCLES = 4
)
(
	input logic clk,
	input logic rst_i,

	// Receive FIFO, show-ahead
	input logic [dbg_pkg::BYTE_W-1:0] rx_data_i,
	input logic rx_empty_i,
	output logic rd_o,

	// Transmit FIFO
	output logic [dbg_pkg::BYTE_W-1:0] tx_data_o,
	input logic tx_full_i,
	output logic wr_o,

	// Target processor
	output logic target_init_o,
	output logic target_en_o,
	input logic target_done_i,
	input logic [SNAP_WORDS*snap_pkg::WORD_W-1:0] snapshot_i
);

	logic cmd_valid;
	dbg_pkg::cmd_op_e cmd_op;
	logic cmd_ready;
	logic dump_start;
	logic dump_done;

	//////////////////////////////
	// Command input
	//////////////////////////////

	cmd_decoder u_cmd_decoder
	(
		.clk(clk),
		.rst_i(rst_i),
		.rx_data_i(rx_data_i),
		.rx_empty_i(rx_empty_i),
		.rd_o(rd_o),
		.cmd_valid_o(cmd_valid),
		.cmd_op_o(cmd_op),
		.cmd_ready_i(cmd_ready)
	);

	//////////////////////////////
	// Target sequencing
	//////////////////////////////

	run_ctrl
	#(
		.INIT_CYCLES(INIT_CYCLES)
	)
	u_run_ctrl
	(
		.clk(clk),
		.rst_i(rst_i),
		.cmd_valid_i(cmd_valid),
		.cmd_op_i(cmd_op),
		.cmd_ready_o(cmd_ready),
		.target_init_o(target_init_o),
		.target_en_o(target_en_o),
		.target_done_i(target_done_i),
		.dump_start_o(dump_start),
		.dump_done_i(dump_done)
	);

	//////////////////////////////
	// Snapshot output
	//////////////////////////////

	snap_serializer
	#(
		.SNAP_WORDS(SNAP_WORDS)
	)
	u_snap_serializer
	(
		.clk(clk),
		.rst_i(rst_i),
		.snapshot_i(snapshot_i),
		.dump_start_i(dump_start),
		.dump_done_o(dump_done),
		.tx_data_o(tx_data_o),
		.tx_full_i(tx_full_i),
		.wr_o(wr_o)
	);

endmodule

//--- debug/snap_serializer.sv
`timescale 1ns/100ps

module snap_serializer
#(
	parameter int SNAP_WORDS = snap_pkg::SNAP_WORDS_DEF
)
(
	input logic clk,
	input logic rst_i,

	input logic [SNAP_WORDS*snap_pkg::WORD_W-1:0] snapshot_i,
	input logic dump_start_i,
	output logic dump_done_o,

	output logic [dbg_pkg::BYTE_W-1:0] tx_data_o,
	input logic tx_full_i,
	output logic wr_o
);

	localparam int WIDX_W = (SNAP_WORDS > 1) ? $clog2(SNAP_WORDS) : 1;
	localparam int BIDX_W = $clog2(snap_pkg::BYTES_PER_WORD);

	logic [snap_pkg::WORD_W-1:0] snap_q [SNAP_WORDS];
	logic [snap_pkg::WORD_W-1:0] cur_word;

	logic busy_q;
	logic done_q;
	logic [WIDX_W-1:0] word_idx_q;
	logic [BIDX_W-1:0] byte_idx_q;
	logic last_in_word;
	logic last_byte;

	//////////////////////////////
	// Snapshot latch
	//////////////////////////////

	// Target may move on after capture
	always_ff @(posedge clk)
	begin
		if (dump_start_i)
		begin
			for (int w = 0; w < SNAP_WORDS; w++)
			begin
				snap_q[w] <= snapshot_i[w*snap_pkg::WORD_W +: snap_pkg::WORD_W];
			end
		end
	end

	//////////////////////////////
	// Byte sequencing
	//////////////////////////////

	assign last_in_word = (byte_idx_q == BIDX_W'(snap_pkg::BYTES_PER_WORD - 1));
	assign last_byte = last_in_word && (word_idx_q == WIDX_W'(SNAP_WORDS - 1));

	// Word 0 first, low byte first
	assign cur_word = snap_q[word_idx_q];
	assign tx_data_o = cur_word[byte_idx_q*dbg_pkg::BYTE_W +: dbg_pkg::BYTE_W];

	assign wr_o = busy_q && !tx_full_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			word_idx_q <= '0;
			byte_idx_q <= '0;
		end
		else
		begin
			done_q <= wr_o && last_byte;
			if (dump_start_i)
			begin
				busy_q <= 1'b1;
				word_idx_q <= '0;
				byte_idx_q <= '0;
			end
			else if (wr_o)
			begin
				if (last_byte)
				begin
					busy_q <= 1'b0;
				end
				if (last_in_word)
				begin
					byte_idx_q <= '0;
					word_idx_q <= word_idx_q + 1'b1;
				end
				else
				begin
					byte_idx_q <= byte_idx_q + 1'b1;
				end
			end
		end
	end

	assign dump_done_o = done_q;

endmodule

//--- debug/run_ctrl.sv
`timescale 1ns/100ps

module run_ctrl
#(
	parameter int INIT_CYCLES = 4
)
(
	input logic clk,
	input logic rst_i,

	input logic cmd_valid_i,
	input dbg_pkg::cmd_op_e cmd_op_i,
	output logic cmd_ready_o,

	output logic target_init_o,
	output logic target_en_o,
	input logic target_done_i,

	output logic dump_start_o,
	input logic dump_done_i
);

	localparam int CNT_W = $clog2(INIT_CYCLES + 1);

	dbg_pkg::ctrl_state_e state_q;
	dbg_pkg::ctrl_state_e state_d;

	logic [CNT_W-1:0] init_cnt_q;
	logic init_q;
	logic init_d;
	logic en_q;
	logic en_d;
	logic capture;

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb
	begin
		state_d = state_q;
		init_d = 1'b0;
		en_d = 1'b0;
		capture = 1'b0;

		case (state_q)
			dbg_pkg::ST_INIT:
			begin
				if (init_cnt_q == CNT_W'(INIT_CYCLES))
				begin
					state_d = dbg_pkg::ST_IDLE;
				end
				else
				begin
					init_d = 1'b1;
				end
			end
			dbg_pkg::ST_IDLE:
			begin
				if (cmd_valid_i)
				begin
					en_d = 1'b1;
					if (cmd_op_i == dbg_pkg::CMD_STEP)
					begin
						state_d = dbg_pkg::ST_STEP;
					end
					else
					begin
						state_d = dbg_pkg::ST_RUN;
					end
				end
			end
			dbg_pkg::ST_RUN:
			begin
				// Done cycle is the last enabled cycle and the capture point
				if (target_done_i)
				begin
					capture = 1'b1;
					state_d = dbg_pkg::ST_DUMP;
				end
				else
				begin
					en_d = 1'b1;
				end
			end
			dbg_pkg::ST_STEP:
			begin
				// First cycle enabled, second one captures
				if (!en_q)
				begin
					capture = 1'b1;
					state_d = dbg_pkg::ST_DUMP;
				end
			end
			dbg_pkg::ST_DUMP:
			begin
				if (dump_done_i)
				begin
					state_d = dbg_pkg::ST_IDLE;
				end
			end
			default:
			begin
				state_d = dbg_pkg::ST_INIT;
			end
		endcase
	end

	//////////////////////////////
	// State and target controls
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= dbg_pkg::ST_INIT;
			init_cnt_q <= '0;
			init_q <= 1'b0;
			en_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			init_q <= init_d;
			en_q <= en_d;
			if (init_d)
			begin
				init_cnt_q <= init_cnt_q + 1'b1;
			end
		end
	end

	assign cmd_ready_o = (state_q == dbg_pkg::ST_IDLE);
	assign target_init_o = init_q;
	assign target_en_o = en_q;
	assign dump_start_o = capture;

endmodule

//--- debug/cmd_decoder.sv
`timescale 1ns/100ps

module cmd_decoder
(
	input logic clk,
	input logic rst_i,

	input logic [dbg_pkg::BYTE_W-1:0] rx_data_i,
	input logic rx_empty_i,
	output logic rd_o,

	output logic cmd_valid_o,
	output dbg_pkg::cmd_op_e cmd_op_o,
	input logic cmd_ready_i
);

	logic cmd_valid_q;
	dbg_pkg::cmd_op_e cmd_op_q;
	logic known_char;
	logic cmd_taken;

	// Pop only into an empty command slot
	assign rd_o = !cmd_valid_q && !rx_empty_i;

	assign known_char = dbg_pkg::is_cmd_char(rx_data_i);
	assign cmd_taken = cmd_valid_q && cmd_ready_i;

	//////////////////////////////
	// Command slot
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			cmd_valid_q <= 1'b0;
		end
		else if (rd_o)
		begin
			// Unknown bytes leave the slot empty
			cmd_valid_q <= known_char;
		end
		else if (cmd_taken)
		begin
			cmd_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_o && known_char)
		begin
			cmd_op_q <= dbg_pkg::char_to_op(rx_data_i);
		end
	end

	assign cmd_valid_o = cmd_valid_q;
	assign cmd_op_o = cmd_op_q;

endmodule

//--- common/snap_pkg.sv
package snap_pkg;

	//////////////////////////////
	// Snapshot layout
	//////////////////////////////

	// Target state is exported as 32-bit words
	localparam int WORD_W = 32;
	localparam int BYTES_PER_WORD = WORD_W / 8;

	// 37 words, 148 bytes on the wire
	localparam int SNAP_WORDS_DEF = 37;

endpackage

//--- common/dbg_pkg.sv
package dbg_pkg;

	//////////////////////////////
	// Byte and command encodings
	//////////////////////////////

	localparam int BYTE_W = 8;

	// ASCII command characters from the host
	localparam logic [BYTE_W-1:0] CHAR_RUN = 8'h63;
	localparam logic [BYTE_W-1:0] CHAR_STEP = 8'h70;

	typedef enum logic [0:0]
	{
		CMD_RUN,
		CMD_STEP
	} cmd_op_e;

	// Debug controller states
	typedef enum logic [2:0]
	{
		ST_INIT,
		ST_IDLE,
		ST_RUN,
		ST_STEP,
		ST_DUMP
	} ctrl_state_e;

	// True for a byte that maps to an opcode
	function automatic logic is_cmd_char(input logic [BYTE_W-1:0] ch);
		return (ch == CHAR_RUN) || (ch == CHAR_STEP);
	endfunction

	// Only meaningful when is_cmd_char holds
	function automatic cmd_op_e char_to_op(input logic [BYTE_W-1:0] ch);
		cmd_op_e op;
		op = CMD_RUN;
		if (ch == CHAR_STEP)
		begin
			op = CMD_STEP;
		end
		return op;
	endfunction

endpackage
